//--- bench/rec_us_patterns.hex
// per test 16 instruction words {opcode[21:18], src1[17:10], src2[9:2], src3, src4}
// followed by one word holding rec_do_prefix in its low 6 bits
// basic: SETNCNT 20, MAC, LOAD, RELUS, SIGMOIDS, RELUP, SIGMOIDP, NOP, HALT
145000 2454CE 21E800 0C0000 100001 180214 1C0040 000000
040000 000000 000000 000000 000000 000000 000000 000000
00002A
// second record: SETNCNT 100, MAC, SIGMOIDP, RELUP, RELUS, HALT
159000 241511 1C03C0 1801FC 0C0001 040000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
000015
// hold: SETNCNT 10, MAC, RELUP, NOPs, HOLD at address 12
142800 24896B 18030C 000000 000000 000000 000000 000000
000000 000000 000000 000000 280000 000000 000000 000000
000007
// resume: LOAD, SIGMOIDS, SIGMOIDP, HALT
204400 100000 1C0004 040000 000000 000000 000000 000000
000000 000000 000000 000000 000000 000000 000000 000000
00003C

//--- bench/rec_us_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rec_us_tb;

  localparam int HALF_PERIOD = 20;
  localparam int TIMEOUT     = 200;
  localparam int N_TESTS     = 4;
  localparam int BLOCK       = 17;
  localparam int DRAIN       = 12;

  logic                                  clk;
  logic                                  rst_n;
  logic [3:0]                            fe_ib_empty;
  logic                                  pf_full;
  rec_us_pkg::rec_inst_t                 im_dout;
  logic [rec_us_pkg::DO_PREFIX_W-1:0]    rec_do_prefix;
  logic                                  fe_rd;
  logic [rec_us_pkg::PC_W-1:0]           im_addr;
  logic                                  im_cs;
  logic                                  halt;
  logic                                  hold;
  logic                                  run;
  logic [rec_us_pkg::ADDR7_W-1:0]        sat_addr;
  logic [rec_us_pkg::ADDR7_W-1:0]        ct_addr;
  logic [1:0]                            drsel;
  logic [rec_us_pkg::N_INNER-1:0]        neuron_en3;
  logic [rec_us_pkg::N_INNER-1:0]        neuron_en4;
  logic [rec_us_pkg::N_OUTER-1:0]        neuron_en5;
  logic                                  ld_lr0;
  logic                                  ld_lr1;
  logic signed [7:0]                     threshold;
  logic                                  prefix_valid;
  logic [rec_us_pkg::PF_W-1:0]           pf_datain;

  logic [21:0]  pattern_mem [0:N_TESTS*BLOCK-1];
  logic [21:0]  prog [0:255];
  string        test_name;

  // expected state carried from one record to the next
  logic [1:0]   exp_drsel;
  logic [6:0]   exp_ct;
  logic [6:0]   exp_sat;
  logic [7:0]   exp_thr;
  logic [127:0] exp_mask;
  int           exp_ld0;
  int           exp_ld1;
  int           exp_pref;
  bit           stops_on_hold;

  bit           counting;
  int           cnt_ld0;
  int           cnt_ld1;
  int           cnt_pref;
  logic [8:0]   last_pf;
  bit           seen3;
  bit           seen4;
  bit           seen5;

  rec_us_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fe_ib_empty   (fe_ib_empty),
    .pf_full       (pf_full),
    .im_dout       (im_dout),
    .rec_do_prefix (rec_do_prefix),
    .fe_rd         (fe_rd),
    .im_addr       (im_addr),
    .im_cs         (im_cs),
    .halt          (halt),
    .hold          (hold),
    .run           (run),
    .sat_addr      (sat_addr),
    .ct_addr       (ct_addr),
    .drsel         (drsel),
    .neuron_en3    (neuron_en3),
    .neuron_en4    (neuron_en4),
    .neuron_en5    (neuron_en5),
    .ld_lr0        (ld_lr0),
    .ld_lr1        (ld_lr1),
    .threshold     (threshold),
    .prefix_valid  (prefix_valid),
    .pf_datain     (pf_datain)
  );

  always #HALF_PERIOD clk = ~clk;

  // the instruction memory is combinational
  assign im_dout = prog[im_addr];

  // pulse counters and mask observations taken on the falling edge
  always @(negedge clk) begin
    if (counting) begin
      if (ld_lr0) cnt_ld0++;
      if (ld_lr1) cnt_ld1++;
      if (prefix_valid) begin
        cnt_pref++;
        last_pf = pf_datain;
      end
      if (neuron_en3 == exp_mask) seen3 = 1'b1;
      if (neuron_en4 == exp_mask) seen4 = 1'b1;
      if (neuron_en5 == exp_mask[63:0]) seen5 = 1'b1;
    end
  end

  function automatic logic [127:0] mask_of(int n);
    logic [127:0] m;
    for (int i = 0; i < 128; i++) begin
      m[i] = (n > i);
    end
    return m;
  endfunction

  task automatic check_value(string what, logic [127:0] exp, logic [127:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(string what);
    $display("%s: timed out waiting for %s", test_name, what);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  endtask

  // *********************************************************************
  // program loading and expected values
  // *********************************************************************
  task automatic load_program(int t);
    for (int a = 0; a < 256; a++) begin
      // addresses outside the block hold a HALT tagged with the address
      if (a < 16) prog[a] = pattern_mem[t*BLOCK+a];
      else prog[a] = {4'(rec_us_pkg::HALT), 8'(a), 10'd0};
    end
    rec_do_prefix = pattern_mem[t*BLOCK+16][5:0];
  endtask

  task automatic compute_expected();
    rec_us_pkg::rec_inst_t inst;
    bit                    done;
    int                    ncnt;
    done     = 1'b0;
    ncnt     = 128;
    exp_ld0  = 0;
    exp_ld1  = 0;
    exp_pref = 0;
    for (int k = 0; k < 16 && !done; k++) begin
      inst = prog[k];
      case (inst.opcode)
        rec_us_pkg::MAC: begin
          exp_drsel = {inst.src3, inst.src4};
          exp_ct    = inst.src1[6:0];
          exp_sat   = inst.src2[6:0];
        end
        rec_us_pkg::LOAD: exp_ct = inst.src1[6:0];
        rec_us_pkg::SETNCNT: ncnt = int'(inst.src1);
        rec_us_pkg::RELUS, rec_us_pkg::SIGMOIDS: begin
          if (inst.src4) exp_ld1++;
          else exp_ld0++;
        end
        rec_us_pkg::RELUP, rec_us_pkg::SIGMOIDP: begin
          exp_thr  = inst.src2;
          exp_pref = 1;
        end
        rec_us_pkg::HALT, rec_us_pkg::HOLD: begin
          done          = 1'b1;
          stops_on_hold = (inst.opcode == rec_us_pkg::HOLD);
        end
        default: ;
      endcase
    end
    exp_mask = mask_of(ncnt);
  endtask

  // *********************************************************************
  // record start, fetch and result checks
  // *********************************************************************
  task automatic start_record();
    int idx;
    int guard;
    guard = 0;
    while (fe_ib_empty != 4'h0) begin
      guard++;
      if (guard > TIMEOUT) fail_timeout("all buffers to report data");
      idx = $urandom % 4;
      fe_ib_empty[idx] = 1'b0;
      @(negedge clk);
      if (fe_ib_empty != 4'h0) begin
        check_value("fe_rd with a buffer empty", 0, fe_rd);
        @(posedge clk);
        #2;
      end
    end
    check_value("fe_rd", 1, fe_rd);
    @(posedge clk);
    #2;
    // the buffers still report data here, so only the valid record holds fe_rd low
    check_value("fe_rd width", 0, fe_rd);
    fe_ib_empty = 4'hf;
    @(negedge clk);
    check_value("im_cs before run", 1, im_cs);
    guard = 0;
    while (!run) begin
      guard++;
      if (guard > TIMEOUT) fail_timeout("run to rise");
      @(negedge clk);
    end
    check_value("start address", 0, im_addr);
  endtask

  task automatic follow_fetch();
    rec_us_pkg::rec_inst_t inst;
    int                    k;
    k    = 0;
    inst = prog[0];
    while (inst.opcode != rec_us_pkg::HALT && inst.opcode != rec_us_pkg::HOLD) begin
      check_value("im_addr", k, im_addr);
      check_value("run during fetch", 1, run);
      check_value("im_cs during fetch", 1, im_cs);
      k++;
      if (k > 255) fail_timeout("a HALT or HOLD word");
      inst = prog[k];
      @(negedge clk);
    end
    check_value("im_addr at stop", k, im_addr);
    check_value("im_cs at stop", 0, im_cs);
    @(negedge clk);
    check_value("run after stop", 0, run);
    check_value("im_addr after stop", 0, im_addr);
    check_value("halt after stop", !stops_on_hold, halt);
    check_value("hold after stop", stops_on_hold, hold);
  endtask

  task automatic check_results();
    check_value("drsel", exp_drsel, drsel);
    check_value("ct_addr", exp_ct, ct_addr);
    check_value("sat_addr", exp_sat, sat_addr);
    check_value("threshold", exp_thr, $unsigned(threshold));
    check_value("ld_lr0 cycles", exp_ld0, cnt_ld0);
    check_value("ld_lr1 cycles", exp_ld1, cnt_ld1);
    check_value("prefix_valid pulses", exp_pref, cnt_pref);
    if (exp_pref != 0) check_value("pf_datain", {3'b000, rec_do_prefix}, last_pf);
    check_value("neuron_en3 seen", 1, seen3);
    check_value("neuron_en4 seen", 1, seen4);
    check_value("neuron_en5 seen", 1, seen5);
    // a halted record has its counts restored while a held one keeps them
    if (stops_on_hold) begin
      check_value("neuron_en3", exp_mask, neuron_en3);
      check_value("neuron_en5", exp_mask[63:0], neuron_en5);
    end else begin
      check_value("neuron_en3", {128{1'b1}}, neuron_en3);
      check_value("neuron_en4", {128{1'b1}}, neuron_en4);
      check_value("neuron_en5", {64{1'b1}}, neuron_en5);
    end
  endtask

  initial begin
    string names [N_TESTS];
    names = '{"basic", "second_record", "hold", "resume"};
    void'($urandom(32'h738));
    clk           = 1'b0;
    rst_n         = 1'b0;
    fe_ib_empty   = 4'hf;
    pf_full       = 1'b0;
    rec_do_prefix = '0;
    counting      = 1'b0;
    exp_drsel     = '0;
    exp_ct        = '0;
    exp_sat       = '0;
    exp_thr       = '0;
    $readmemh("bench/rec_us_patterns.hex", pattern_mem);
    load_program(0);
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_name = "reset";
    @(negedge clk);
    check_value("halt", 0, halt);
    check_value("run", 0, run);
    check_value("hold", 0, hold);
    check_value("ld_lr", 0, {ld_lr1, ld_lr0});
    check_value("prefix_valid", 0, prefix_valid);
    check_value("fe_rd", 0, fe_rd);
    check_value("im_cs", 0, im_cs);
    check_value("neuron_en3", {128{1'b1}}, neuron_en3);
    check_value("neuron_en4", {128{1'b1}}, neuron_en4);
    check_value("neuron_en5", {64{1'b1}}, neuron_en5);

    // halt comes up on the first clock edge out of reset
    @(negedge clk);
    check_value("halt after first edge", 1, halt);
    check_value("run after first edge", 0, run);

    // a full prefix FIFO keeps a new record from starting
    @(posedge clk);
    #2;
    pf_full     = 1'b1;
    fe_ib_empty = 4'h0;
    repeat (6) begin
      @(negedge clk);
      check_value("fe_rd with pf_full", 0, fe_rd);
      check_value("run with pf_full", 0, run);
    end
    @(posedge clk);
    #2;
    fe_ib_empty = 4'hf;
    pf_full     = 1'b0;

    for (int t = 0; t < N_TESTS; t++) begin
      test_name = names[t];
      load_program(t);
      compute_expected();
      cnt_ld0  = 0;
      cnt_ld1  = 0;
      cnt_pref = 0;
      seen3    = 1'b0;
      seen4    = 1'b0;
      seen5    = 1'b0;
      counting = 1'b1;
      start_record();
      follow_fetch();
      repeat (DRAIN) @(negedge clk);
      check_results();
      if (stops_on_hold) begin
        repeat (6) begin
          @(negedge clk);
          check_value("hold level", 1, hold);
          check_value("drsel in hold", exp_drsel, drsel);
          check_value("ct_addr in hold", exp_ct, ct_addr);
          check_value("threshold in hold", exp_thr, $unsigned(threshold));
          check_value("neuron_en4 in hold", exp_mask, neuron_en4);
        end
      end
      @(posedge clk);
      #2;
      counting = 1'b0;
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/rec_neuron_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rec_neuron_stage (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             hold,
  input  wire rec_us_pkg::rec_inst_t            ir2,
  output logic [rec_us_pkg::N_INNER-1:0]        neuron_en3,
  output logic [rec_us_pkg::N_INNER-1:0]        neuron_en4,
  output logic [rec_us_pkg::N_OUTER-1:0]        neuron_en5,
  output logic                                  ld_lr0,
  output logic                                  ld_lr1,
  output rec_us_pkg::rec_inst_t                 ir5
);

  rec_us_pkg::rec_inst_t             ir3;
  rec_us_pkg::rec_inst_t             ir4;
  logic [rec_us_pkg::NCNT_W-1:0]     ncnt3;
  logic [rec_us_pkg::NCNT_W-1:0]     ncnt4;
  logic [rec_us_pkg::NCNT_W-1:0]     ncnt5;

  // **********************************************************************
  // each enable mask sets bit i while its count is above i
  // **********************************************************************
  for (genvar i = 0; i < rec_us_pkg::N_INNER; i++) begin : g_mask
    assign neuron_en3[i] = (ncnt3 > rec_us_pkg::NCNT_W'(i));
    assign neuron_en4[i] = (ncnt4 > rec_us_pkg::NCNT_W'(i));
    // the output layer only has the lower half of the neurons
    if (i < rec_us_pkg::N_OUTER) begin : g_outer
      assign neuron_en5[i] = (ncnt5 > rec_us_pkg::NCNT_W'(i));
    end
  end

  // **********************************************************************
  // stages 3 to 5
  // **********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir3    <= rec_us_pkg::INST_NOP;
      ir4    <= rec_us_pkg::INST_NOP;
      ir5    <= rec_us_pkg::INST_NOP;
      ncnt3  <= rec_us_pkg::NCNT_RESET;
      ncnt4  <= rec_us_pkg::NCNT_RESET;
      ncnt5  <= rec_us_pkg::NCNT_RESET;
      ld_lr0 <= 1'b0;
      ld_lr1 <= 1'b0;
    end else if (!hold) begin
      ir3 <= ir2;
      if (ir2.opcode == rec_us_pkg::SETNCNT) begin
        ncnt3 <= ir2.src1;
      end else if (ir2.opcode == rec_us_pkg::HALT) begin
        ncnt3 <= rec_us_pkg::NCNT_RESET;
      end

      ir4   <= ir3;
      ncnt4 <= ncnt3;

      ir5   <= ir4;
      ncnt5 <= ncnt4;

      // src4 picks which layer register takes the stored activations
      if ((ir4.opcode == rec_us_pkg::RELUS) || (ir4.opcode == rec_us_pkg::SIGMOIDS)) begin
        ld_lr0 <= ~ir4.src4;
        ld_lr1 <= ir4.src4;
      end else begin
        ld_lr0 <= 1'b0;
        ld_lr1 <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rec_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rec_operand_stage (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             hold,
  input  wire rec_us_pkg::rec_inst_t            ir0,
  output logic [1:0]                            drsel,
  output logic [rec_us_pkg::ADDR7_W-1:0]        ct_addr,
  output rec_us_pkg::rec_inst_t                 ir2
);

  rec_us_pkg::rec_inst_t ir1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir1     <= rec_us_pkg::INST_NOP;
      ir2     <= rec_us_pkg::INST_NOP;
      drsel   <= 2'd0;
      ct_addr <= '0;
    end else if (!hold) begin
      // stage 1 decodes the weight bank and coefficient address
      ir1 <= ir0;

      if (ir0.opcode == rec_us_pkg::MAC) begin
        drsel <= {ir0.src3, ir0.src4};
      end

      if ((ir0.opcode == rec_us_pkg::MAC) || (ir0.opcode == rec_us_pkg::LOAD)) begin
        ct_addr <= ir0.src1[rec_us_pkg::ADDR7_W-1:0];
      end

      // stage 2 lines the instruction up with the neuron count stage
      ir2 <= ir1;
    end
  end

endmodule

`default_nettype wire

//--- design/rec_prefix_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rec_prefix_stage (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             hold,
  input  wire rec_us_pkg::rec_inst_t            ir5,
  input  wire logic [rec_us_pkg::DO_PREFIX_W-1:0] rec_do_prefix,
  output logic signed [7:0]                     threshold,
  output logic                                  prefix_valid,
  output logic [rec_us_pkg::PF_W-1:0]           pf_datain
);

  rec_us_pkg::rec_inst_t ir6;
  rec_us_pkg::rec_inst_t ir7;
  logic                  written;
  logic                  written_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir6          <= rec_us_pkg::INST_NOP;
      ir7          <= rec_us_pkg::INST_NOP;
      threshold    <= '0;
      pf_datain    <= '0;
      written      <= 1'b0;
      written_d    <= 1'b0;
      prefix_valid <= 1'b0;
    end else begin
      // the FIFO write strobe is one pulse per record, even across a hold
      written_d    <= written;
      prefix_valid <= written & ~written_d;

      if (!hold) begin
        ir6 <= ir5;
        if ((ir5.opcode == rec_us_pkg::RELUP) || (ir5.opcode == rec_us_pkg::SIGMOIDP)) begin
          threshold <= $signed(ir5.src2);
        end

        ir7 <= ir6;
        if (!written &&
            ((ir7.opcode == rec_us_pkg::RELUP) || (ir7.opcode == rec_us_pkg::SIGMOIDP))) begin
          written   <= 1'b1;
          pf_datain <= rec_us_pkg::PF_W'(rec_do_prefix);
        end else if (ir7.opcode == rec_us_pkg::HALT) begin
          written <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rec_sequencer (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic [3:0]                       fe_ib_empty,
  input  wire logic                             pf_full,
  input  wire rec_us_pkg::rec_inst_t            im_dout,
  output logic                                  fe_rd,
  output logic [rec_us_pkg::PC_W-1:0]           im_addr,
  output logic                                  im_cs,
  output logic                                  halt,
  output logic                                  hold,
  output logic                                  run,
  output logic [rec_us_pkg::ADDR7_W-1:0]        sat_addr,
  output rec_us_pkg::rec_inst_t                 ir0
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    WAIT
  } state_e;

  state_e                            state;
  state_e                            next_state;
  logic [rec_us_pkg::PC_W-1:0]       pc;
  logic                              ip_valid;

  // a record is read only when every buffer has data and the prefix FIFO has room
  assign fe_rd   = (&(~fe_ib_empty)) & ~pf_full & ~ip_valid;
  assign im_addr = pc;
  assign im_cs   = (next_state == RUN);

  // **********************************************************************
  // fetch state machine
  // **********************************************************************
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (ip_valid) begin
          next_state = RUN;
        end
      end
      RUN: begin
        if (im_dout.opcode == rec_us_pkg::HALT) begin
          next_state = IDLE;
        end else if (im_dout.opcode == rec_us_pkg::HOLD) begin
          next_state = WAIT;
        end
      end
      WAIT: begin
        if (fe_rd) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      pc       <= '0;
      ip_valid <= 1'b0;
      run      <= 1'b0;
      halt     <= 1'b0;
      hold     <= 1'b0;
    end else begin
      state <= next_state;
      run   <= (next_state == RUN);
      halt  <= (next_state == IDLE);
      hold  <= (next_state == WAIT);

      // the program always starts at address 0, so the counter only moves inside RUN
      if ((state == RUN) && (next_state == RUN)) begin
        pc <= pc + 1'b1;
      end else begin
        pc <= '0;
      end

      if (fe_rd) begin
        ip_valid <= 1'b1;
      end else if ((state == RUN) && (next_state != RUN)) begin
        ip_valid <= 1'b0;
      end
    end
  end

  // **********************************************************************
  // stage 0 issue register
  // **********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir0      <= rec_us_pkg::INST_NOP;
      sat_addr <= '0;
    end else begin
      // while halted a HALT is pushed down the pipe to restore the neuron counts
      if (halt) begin
        ir0 <= rec_us_pkg::INST_HALT;
      end else if (run) begin
        ir0 <= im_dout;
      end

      if (im_dout.opcode == rec_us_pkg::MAC) begin
        sat_addr <= im_dout.src2[rec_us_pkg::ADDR7_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rec_us_pkg.sv
`default_nettype none

package rec_us_pkg;

  // **********************************************************************
  // widths
  // **********************************************************************
  localparam int PC_W        = 8;
  localparam int ADDR7_W     = 7;
  localparam int NCNT_W      = 8;
  localparam int N_INNER     = 128;
  localparam int N_OUTER     = 64;
  localparam int PF_W        = 9;
  localparam int DO_PREFIX_W = 6;

  // neuron count after reset and after a HALT has passed stage 3
  localparam logic [NCNT_W-1:0] NCNT_RESET = NCNT_W'(128);

  // **********************************************************************
  // instruction encoding
  // **********************************************************************
  // UNLOCK is kept in the encoding but decodes as a NOP
  typedef enum logic [3:0] {
    NOP      = 4'd0,
    HALT     = 4'd1,
    UNLOCK   = 4'd2,
    RELUS    = 4'd3,
    SIGMOIDS = 4'd4,
    SETNCNT  = 4'd5,
    RELUP    = 4'd6,
    SIGMOIDP = 4'd7,
    LOAD     = 4'd8,
    MAC      = 4'd9,
    HOLD     = 4'd10
  } opcode_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [7:0] src1;
    logic [7:0] src2;
    logic       src3;
    logic       src4;
  } rec_inst_t;

  localparam rec_inst_t INST_NOP  = '{opcode: NOP, src1: '0, src2: '0, src3: 1'b0, src4: 1'b0};
  localparam rec_inst_t INST_HALT = '{opcode: HALT, src1: '0, src2: '0, src3: 1'b0, src4: 1'b0};

endpackage

`default_nettype wire

//--- design/rec_us_top.sv
`timescale 1ns/1ps
`default_nettype none

module rec_us_top (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic [3:0]                         fe_ib_empty,
  input  wire logic                               pf_full,
  input  wire rec_us_pkg::rec_inst_t              im_dout,
  input  wire logic [rec_us_pkg::DO_PREFIX_W-1:0] rec_do_prefix,
  output logic                                    fe_rd,
  output logic [rec_us_pkg::PC_W-1:0]             im_addr,
  output logic                                    im_cs,
  output logic                                    halt,
  output logic                                    hold,
  output logic                                    run,
  output logic [rec_us_pkg::ADDR7_W-1:0]          sat_addr,
  output logic [rec_us_pkg::ADDR7_W-1:0]          ct_addr,
  output logic [1:0]                              drsel,
  output logic [rec_us_pkg::N_INNER-1:0]          neuron_en3,
  output logic [rec_us_pkg::N_INNER-1:0]          neuron_en4,
  output logic [rec_us_pkg::N_OUTER-1:0]          neuron_en5,
  output logic                                    ld_lr0,
  output logic                                    ld_lr1,
  output logic signed [7:0]                       threshold,
  output logic                                    prefix_valid,
  output logic [rec_us_pkg::PF_W-1:0]             pf_datain
);

  rec_us_pkg::rec_inst_t ir0;
  rec_us_pkg::rec_inst_t ir2;
  rec_us_pkg::rec_inst_t ir5;

  rec_sequencer u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .fe_ib_empty (fe_ib_empty),
    .pf_full     (pf_full),
    .im_dout     (im_dout),
    .fe_rd       (fe_rd),
    .im_addr     (im_addr),
    .im_cs       (im_cs),
    .halt        (halt),
    .hold        (hold),
    .run         (run),
    .sat_addr    (sat_addr),
    .ir0         (ir0)
  );

  rec_operand_stage u_operand (
    .clk     (clk),
    .rst_n   (rst_n),
    .hold    (hold),
    .ir0     (ir0),
    .drsel   (drsel),
    .ct_addr (ct_addr),
    .ir2     (ir2)
  );

  rec_neuron_stage u_neuron (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .ir2        (ir2),
    .neuron_en3 (neuron_en3),
    .neuron_en4 (neuron_en4),
    .neuron_en5 (neuron_en5),
    .ld_lr0     (ld_lr0),
    .ld_lr1     (ld_lr1),
    .ir5        (ir5)
  );

  rec_prefix_stage u_prefix (
    .clk           (clk),
    .rst_n         (rst_n),
    .hold          (hold),
    .ir5           (ir5),
    .rec_do_prefix (rec_do_prefix),
    .threshold     (threshold),
    .prefix_valid  (prefix_valid),
    .pf_datain     (pf_datain)
  );

endmodule

`default_nettype wire

//--- files.f
design/rec_us_pkg.sv
design/rec_sequencer.sv
design/rec_operand_stage.sv
design/rec_neuron_stage.sv
design/rec_prefix_stage.sv
design/rec_us_top.sv
bench/rec_us_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary -f files.f --top-module rec_us_tb -o rec_us_sim \
  && ./obj_dir/rec_us_sim \
  || exit 1
